//--- src/lenet_pkg.sv
package lenet_pkg;

    // Pixel and weight magnitude width
    localparam int DATA_W = 8;

    // Full width of the 8x8 product
    localparam int PROD_W = 2 * DATA_W;

    // 5x5 window
    localparam int TAPS = 25;
    localparam int TAP_CNT_W = 5;

    // Index of the closing tap of a window
    localparam logic [TAP_CNT_W-1:0] LAST_TAP = TAP_CNT_W'(TAPS - 1);

    // Signed accumulator, room for 25 full-scale products plus bias
    localparam int ACC_W = 24;

    // Signed bias loaded from outside
    localparam int BIAS_W = 16;

    // Requantization of the accumulated sum
    localparam int OUT_SHIFT = 8;
    localparam logic [DATA_W-1:0] OUT_MAX = DATA_W'(255);

endpackage

//--- src/approx_mul8.sv
`timescale 1ns/100ps

module approx_mul8 (
    input  logic [lenet_pkg::DATA_W-1:0] a,
    input  logic [lenet_pkg::DATA_W-1:0] b,
    output logic [lenet_pkg::PROD_W-1:0] p
);

    // One AND row per multiplier bit
    logic [lenet_pkg::DATA_W-1:0] pp [lenet_pkg::DATA_W];

    // Rows for a[7:6], placed at their exact weight
    logic [lenet_pkg::PROD_W-1:0] row6;
    logic [lenet_pkg::PROD_W-1:0] row7;

    // Compressed replacement for rows a[5:0]
    logic [lenet_pkg::PROD_W-1:0] corr1;
    logic [lenet_pkg::PROD_W-1:0] corr2;
    logic [lenet_pkg::PROD_W-1:0] corr3;
    logic [lenet_pkg::PROD_W-1:0] corr4;
    logic [lenet_pkg::PROD_W-1:0] corr5;

    genvar i;
    generate
        for (i = 0; i < lenet_pkg::DATA_W; i++) begin : g_row
            assign pp[i] = b & {lenet_pkg::DATA_W{a[i]}};
        end
    endgenerate

    assign row6 = {2'b00, pp[6], 6'b00_0000};
    assign row7 = {1'b0, pp[7], 7'b000_0000};

    // Pairs of neighbouring rows merged with AND, OR and XOR
    always_comb begin
        corr1 = '0;
        corr1[2]  = pp[0][1] & pp[1][0];
        corr1[3]  = pp[0][3] ^ pp[1][2];
        corr1[6]  = pp[4][1] ^ pp[5][0];
        corr1[7]  = pp[2][5] | pp[3][4];
        corr1[8]  = pp[0][7] ^ pp[1][6];
        corr1[9]  = pp[2][7] | pp[3][6];
        corr1[10] = pp[2][7] & pp[3][6];
        corr1[11] = pp[4][6] & pp[5][5];
        corr1[12] = pp[4][7] & pp[5][6];
    end

    always_comb begin
        corr2 = '0;
        corr2[7]  = pp[2][5] ^ pp[3][4];
        corr2[8]  = pp[2][6] | pp[3][5];
        corr2[9]  = pp[4][5] & pp[5][4];
        corr2[10] = pp[3][7];
        corr2[11] = pp[4][7] ^ pp[5][6];
        corr2[12] = pp[5][7];
    end

    // Sparse vectors fed mostly by rows a[5:4]
    always_comb begin
        corr3 = '0;
        corr3[7]  = pp[4][2] | pp[5][1];
        corr3[8]  = pp[4][3] & pp[5][2];
        corr3[9]  = pp[4][5] | pp[5][4];
        corr3[10] = pp[4][6] ^ pp[5][5];
    end

    always_comb begin
        corr4 = '0;
        corr4[7] = pp[4][3] | pp[5][2];
        corr4[8] = pp[4][4] & pp[5][3];
    end

    always_comb begin
        corr5 = '0;
        corr5[8] = pp[4][4] | pp[5][3];
    end

    // Exact whenever a[5:0] is zero, all corrections vanish then
    assign p = row6 + row7 + corr1 + corr2 + corr3 + corr4 + corr5;

endmodule

//--- src/tap_sequencer.sv
`timescale 1ns/100ps

module tap_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         tap_valid,
    input  logic [lenet_pkg::DATA_W-1:0] pixel,
    input  logic [lenet_pkg::DATA_W-1:0] weight_mag,
    input  logic                         weight_neg,
    output logic                         s_valid,
    output logic [lenet_pkg::DATA_W-1:0] s_pixel,
    output logic [lenet_pkg::DATA_W-1:0] s_weight_mag,
    output logic                         s_weight_neg,
    output logic                         s_first,
    output logic                         s_last
);

    // Position of the next tap inside its window
    logic [lenet_pkg::TAP_CNT_W-1:0] tap_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_valid <= 1'b0;
            s_first <= 1'b0;
            s_last  <= 1'b0;
            tap_idx <= '0;
        end else begin
            s_valid <= tap_valid;
            if (tap_valid) begin
                s_first <= (tap_idx == '0);
                s_last  <= (tap_idx == lenet_pkg::LAST_TAP);
                // Wrap so the next strobe opens a new window
                if (tap_idx == lenet_pkg::LAST_TAP) begin
                    tap_idx <= '0;
                end else begin
                    tap_idx <= tap_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tap_valid) begin
            s_pixel      <= pixel;
            s_weight_mag <= weight_mag;
            s_weight_neg <= weight_neg;
        end
    end

    a_idx_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        tap_idx <= lenet_pkg::LAST_TAP
    );

endmodule

//--- src/window_mac.sv
`timescale 1ns/100ps

module window_mac (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                s_valid,
    input  logic [lenet_pkg::DATA_W-1:0]        s_pixel,
    input  logic [lenet_pkg::DATA_W-1:0]        s_weight_mag,
    input  logic                                s_weight_neg,
    input  logic                                s_first,
    input  logic                                s_last,
    input  logic                                bias_load,
    input  logic signed [lenet_pkg::BIAS_W-1:0] bias,
    output logic                                acc_done,
    output logic signed [lenet_pkg::ACC_W-1:0]  acc_sum
);

    logic [lenet_pkg::PROD_W-1:0] mul_p;

    // Product stage
    logic                         p_valid;
    logic [lenet_pkg::PROD_W-1:0] p_prod;
    logic                         p_neg;
    logic                         p_first;
    logic                         p_last;

    logic signed [lenet_pkg::BIAS_W-1:0] bias_q;
    logic signed [lenet_pkg::ACC_W-1:0]  prod_ext;
    logic signed [lenet_pkg::ACC_W-1:0]  prod_signed;
    logic signed [lenet_pkg::ACC_W-1:0]  acc_base;
    logic signed [lenet_pkg::ACC_W-1:0]  acc_next;
    logic signed [lenet_pkg::ACC_W-1:0]  acc;

    approx_mul8 approx_mul8_i (
        .a (s_weight_mag),
        .b (s_pixel),
        .p (mul_p)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p_valid  <= 1'b0;
            acc_done <= 1'b0;
            bias_q   <= '0;
        end else begin
            p_valid  <= s_valid;
            acc_done <= p_valid & p_last;
            if (bias_load) begin
                bias_q <= bias;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid) begin
            p_prod  <= mul_p;
            p_neg   <= s_weight_neg;
            p_first <= s_first;
            p_last  <= s_last;
        end
    end

    // Magnitude is unsigned, apply the weight sign here
    assign prod_ext    = {{(lenet_pkg::ACC_W - lenet_pkg::PROD_W){1'b0}}, p_prod};
    assign prod_signed = p_neg ? -prod_ext : prod_ext;

    // First tap restarts from the bias
    assign acc_base = p_first ?
        {{(lenet_pkg::ACC_W - lenet_pkg::BIAS_W){bias_q[lenet_pkg::BIAS_W-1]}}, bias_q} : acc;
    assign acc_next = acc_base + prod_signed;

    always_ff @(posedge clk) begin
        if (p_valid) begin
            acc <= acc_next;
            if (p_last) begin
                acc_sum <= acc_next;
            end
        end
    end

    a_done_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_done |=> !acc_done
    );

endmodule

//--- src/relu_requant.sv
`timescale 1ns/100ps

module relu_requant (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               acc_done,
    input  logic signed [lenet_pkg::ACC_W-1:0] acc_sum,
    output logic                               out_valid,
    output logic [lenet_pkg::DATA_W-1:0]       out_pixel
);

    logic [lenet_pkg::ACC_W-1:0]  shifted;
    logic [lenet_pkg::DATA_W-1:0] relu_pix;

    // Logical shift, only used when the sum is non-negative
    assign shifted = acc_sum >> lenet_pkg::OUT_SHIFT;

    always_comb begin
        if (acc_sum[lenet_pkg::ACC_W-1]) begin
            relu_pix = '0;
        end else if (shifted >
                     {{(lenet_pkg::ACC_W - lenet_pkg::DATA_W){1'b0}}, lenet_pkg::OUT_MAX}) begin
            // Clip to the 8-bit range
            relu_pix = lenet_pkg::OUT_MAX;
        end else begin
            relu_pix = shifted[lenet_pkg::DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_pixel <= '0;
        end else begin
            out_valid <= acc_done;
            // Pixel holds until the next window completes
            if (acc_done) begin
                out_pixel <= relu_pix;
            end
        end
    end

    a_valid_after_done : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(acc_done)
    );

endmodule

//--- src/conv_tap_engine.sv
`timescale 1ns/100ps

module conv_tap_engine (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tap_valid,
    input  logic [lenet_pkg::DATA_W-1:0]        pixel,
    input  logic [lenet_pkg::DATA_W-1:0]        weight_mag,
    input  logic                                weight_neg,
    input  logic                                bias_load,
    input  logic signed [lenet_pkg::BIAS_W-1:0] bias,
    output logic                                out_valid,
    output logic [lenet_pkg::DATA_W-1:0]        out_pixel
);

    // Sequenced taps
    logic                         s_valid;
    logic [lenet_pkg::DATA_W-1:0] s_pixel;
    logic [lenet_pkg::DATA_W-1:0] s_weight_mag;
    logic                         s_weight_neg;
    logic                         s_first;
    logic                         s_last;

    // Window result
    logic                               acc_done;
    logic signed [lenet_pkg::ACC_W-1:0] acc_sum;

    tap_sequencer tap_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tap_valid    (tap_valid),
        .pixel        (pixel),
        .weight_mag   (weight_mag),
        .weight_neg   (weight_neg),
        .s_valid      (s_valid),
        .s_pixel      (s_pixel),
        .s_weight_mag (s_weight_mag),
        .s_weight_neg (s_weight_neg),
        .s_first      (s_first),
        .s_last       (s_last)
    );

    window_mac window_mac_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_valid      (s_valid),
        .s_pixel      (s_pixel),
        .s_weight_mag (s_weight_mag),
        .s_weight_neg (s_weight_neg),
        .s_first      (s_first),
        .s_last       (s_last),
        .bias_load    (bias_load),
        .bias         (bias),
        .acc_done     (acc_done),
        .acc_sum      (acc_sum)
    );

    relu_requant relu_requant_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_done  (acc_done),
        .acc_sum   (acc_sum),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

//--- tb/tb_conv_tap_engine.sv
`timescale 1ns/100ps

module tb_conv_tap_engine;

    // Upper bound on windows sent, sizes the run limit
    localparam int MAX_WINDOWS = 40;
    localparam int CYCLE_LIMIT = MAX_WINDOWS * 50 + 200;

    logic                                clk;
    logic                                rst_n;
    logic                                tap_valid;
    logic [lenet_pkg::DATA_W-1:0]        pixel;
    logic [lenet_pkg::DATA_W-1:0]        weight_mag;
    logic                                weight_neg;
    logic                                bias_load;
    logic signed [lenet_pkg::BIAS_W-1:0] bias;
    logic                                out_valid;
    logic [lenet_pkg::DATA_W-1:0]        out_pixel;

    // High while the closing tap of a window is driven
    logic                                last_sent;
    logic signed [lenet_pkg::BIAS_W-1:0] cur_bias;

    logic [lenet_pkg::DATA_W-1:0] exp_q [$];
    logic [lenet_pkg::DATA_W-1:0] exp_head;
    int                           exp_cnt;

    integer seed;
    int     windows_sent;
    int     pulse_cnt;
    int     cycle_cnt;
    int     value_errors;
    int     timing_errors;
    int     count_errors;

    conv_tap_engine conv_tap_engine_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tap_valid  (tap_valid),
        .pixel      (pixel),
        .weight_mag (weight_mag),
        .weight_neg (weight_neg),
        .bias_load  (bias_load),
        .bias       (bias),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel)
    );

    always #20 clk = ~clk;

    task automatic print_error_counts();
        $display("Errors: value %0d, timing %0d, count %0d, windows %0d, pulses %0d",
                 value_errors, timing_errors, count_errors, windows_sent, pulse_cnt);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
            tap_valid = 1'b0;
            last_sent = 1'b0;
        end
    endtask

    task automatic load_bias(input logic signed [lenet_pkg::BIAS_W-1:0] value);
        @(posedge clk);
        #2;
        tap_valid = 1'b0;
        last_sent = 1'b0;
        bias_load = 1'b1;
        bias      = value;
        @(posedge clk);
        #2;
        bias_load = 1'b0;
        cur_bias  = value;
    endtask

    // Weights come from {0, 64, 128, 192}, where the multiplier is exact
    task automatic send_window(input bit zero_w, input bit rand_sign, input bit gaps,
                               input logic [lenet_pkg::DATA_W-1:0] pix_mask);
        logic [31:0]                  rnd;
        logic [lenet_pkg::DATA_W-1:0] pix;
        logic [lenet_pkg::DATA_W-1:0] mag;
        logic                         neg;
        logic [lenet_pkg::DATA_W-1:0] expected;
        int                           sum;
        int                           prod;
        int                           shifted;
        int                           t;
        sum = {{(32 - lenet_pkg::BIAS_W){cur_bias[lenet_pkg::BIAS_W-1]}}, cur_bias};
        for (t = 0; t < lenet_pkg::TAPS; t++) begin
            rnd = $random(seed);
            pix = rnd[7:0] & pix_mask;
            mag = zero_w ? 8'd0 : {rnd[9:8], 6'b00_0000};
            neg = rand_sign & rnd[10];
            if (gaps) begin
                idle(int'(rnd[12:11]));
            end
            prod = {24'd0, pix} * {24'd0, mag};
            if (neg) begin
                sum = sum - prod;
            end else begin
                sum = sum + prod;
            end
            @(posedge clk);
            #2;
            tap_valid  = 1'b1;
            pixel      = pix;
            weight_mag = mag;
            weight_neg = neg;
            last_sent  = (t == lenet_pkg::TAPS - 1);
        end
        // ReLU, shift, clip
        shifted = sum >>> lenet_pkg::OUT_SHIFT;
        if (sum < 0) begin
            expected = '0;
        end else if (shifted > int'(lenet_pkg::OUT_MAX)) begin
            expected = lenet_pkg::OUT_MAX;
        end else begin
            expected = shifted[lenet_pkg::DATA_W-1:0];
        end
        exp_q.push_back(expected);
        exp_head = exp_q[0];
        exp_cnt  = exp_q.size();
        windows_sent++;
    endtask

    // Retire the queue head on each result pulse
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            pulse_cnt++;
            if (exp_q.size() > 0) begin
                exp_q.delete(0);
            end
            exp_cnt = exp_q.size();
            if (exp_cnt > 0) begin
                exp_head = exp_q[0];
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            print_error_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    a_pulse_expected : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (exp_cnt > 0)
    ) else begin
        value_errors++;
        $display("Result pulse arrived with no window pending");
    end

    a_pixel : assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && exp_cnt > 0) |-> (out_pixel == exp_head)
    ) else begin
        value_errors++;
        $display("ERROR out_pixel=%h expected=%h", $sampled(out_pixel), $sampled(exp_head));
    end

    // Last tap sampled at edge n, pulse seen at edge n+4
    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(last_sent, 4)
    ) else begin
        timing_errors++;
        $display("Result pulse timing wrong, out_valid does not follow the last tap by 3 cycles");
    end

    a_reset_pixel : assert property (
        @(posedge clk) disable iff (!rst_n)
        (pulse_cnt == 0 && !out_valid) |-> (out_pixel == '0)
    ) else begin
        value_errors++;
        $display("ERROR out_pixel=%h expected=%h before first result", $sampled(out_pixel),
                 8'h00);
    end

    initial begin
        seed          = 32'h373d_27d6;
        clk           = 1'b0;
        rst_n         = 1'b0;
        tap_valid     = 1'b0;
        pixel         = '0;
        weight_mag    = '0;
        weight_neg    = 1'b0;
        bias_load     = 1'b0;
        bias          = '0;
        last_sent     = 1'b0;
        cur_bias      = '0;
        exp_head      = '0;
        exp_cnt       = 0;
        windows_sent  = 0;
        pulse_cnt     = 0;
        cycle_cnt     = 0;
        value_errors  = 0;
        timing_errors = 0;
        count_errors  = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(3);

        // Zero weights, output is the bias alone
        load_bias(16'sd5000);
        send_window(1'b1, 1'b0, 1'b0, 8'hff);
        load_bias(16'sh7fff);
        send_window(1'b1, 1'b0, 1'b0, 8'hff);
        load_bias(-16'sd3000);
        send_window(1'b1, 1'b0, 1'b0, 8'hff);

        // Positive weights, back to back, full and small pixels
        load_bias(16'sd200);
        repeat (4) send_window(1'b0, 1'b0, 1'b0, 8'hff);
        repeat (4) send_window(1'b0, 1'b0, 1'b0, 8'h0f);
        idle(2);

        // Mixed signs
        load_bias(16'sd1000);
        repeat (5) begin
            send_window(1'b0, 1'b1, 1'b0, 8'hff);
            send_window(1'b0, 1'b1, 1'b0, 8'h3f);
        end

        // Random gaps between taps
        repeat (6) send_window(1'b0, 1'b1, 1'b1, 8'h3f);

        // Reload right behind a window still in flight
        send_window(1'b0, 1'b0, 1'b0, 8'h0f);
        load_bias(16'sd12000);
        repeat (2) send_window(1'b0, 1'b0, 1'b0, 8'h0f);
        load_bias(-16'sd20000);
        repeat (2) send_window(1'b0, 1'b0, 1'b0, 8'h0f);
        idle(1);

        while (exp_cnt != 0) begin
            @(posedge clk);
        end
        idle(6);

        a_pulse_count : assert (pulse_cnt == windows_sent) else begin
            count_errors++;
            $display("Saw %0d result pulses for %0d windows sent", pulse_cnt, windows_sent);
        end

        print_error_counts();
        if (value_errors + timing_errors + count_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
src/lenet_pkg.sv
src/approx_mul8.sv
src/tap_sequencer.sv
src/window_mac.sv
src/relu_requant.sv
src/conv_tap_engine.sv
tb/tb_conv_tap_engine.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv tap engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_conv_tap_engine \
    -f all.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
